// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line appears
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f sources.f --top-module pr_sim_wrapper_tb -Mdir obj_dir || exit 1
out=$(./obj_dir/Vpr_sim_wrapper_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && echo "Simulation passed" || {
	echo "Simulation did not pass"
	exit 1
}

// File: source/and_gate.sv
////////////////////
// AND persona for the reconfigurable slot.
// Bit 0 is a registered AND of the inputs and bit 1 is bit 0 one
// cycle later, so the result carries a short history of the gate.
////////////////////

`timescale 1ns/1ps

module and_gate (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  a,
	input  logic                                  b,
	output logic [pr_region_pkg::OUTPUT_WIDTH-1:0] result
);

	// Reset clears the gate output and its history bit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			// Current product of the inputs
			result[0] <= a & b;
			// Product from the cycle before
			result[1] <= result[0];
		end
	end

endmodule

// File: source/counter.sv
////////////////////
// Counter persona for the reconfigurable slot.
// Counts the cycles in which a is high and wraps at the result width.
// A high b clears the count and wins over a in the same cycle.
////////////////////

`timescale 1ns/1ps

module counter (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  a,
	input  logic                                  b,
	output logic [pr_region_pkg::OUTPUT_WIDTH-1:0] result
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (b) begin
			// Clear has priority over counting
			result <= '0;
		end else if (a) begin
			// Natural overflow gives the modulo wrap
			result <= result + 1'b1;
		end
	end

endmodule

// File: source/freeze_logic_controller.sv
////////////////////
// Freeze block at the region boundary.
// Passes the region result through while freeze is low and keeps a copy
// of it. While freeze is high the copy is driven in its place, so the
// outside world sees the last good result during a swap.
////////////////////

`timescale 1ns/1ps

module freeze_logic_controller (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [pr_region_pkg::OUTPUT_WIDTH-1:0] data_in,
	input  logic                                  freeze,
	output logic [pr_region_pkg::OUTPUT_WIDTH-1:0] data_out
);

	// Last value seen while the region was live
	logic [pr_region_pkg::OUTPUT_WIDTH-1:0] last_good;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_good <= '0;
		end else if (!freeze) begin
			last_good <= data_in;
		end
	end

	// No added latency while the region is live
	assign data_out = freeze ? last_good : data_in;

endmodule

// File: source/fsm.sv
////////////////////
// FSM persona for the reconfigurable slot.
// A Moore machine that spots a followed by b on the next cycle.
// The state code itself is the result: idle, seen-a or matched.
////////////////////

`timescale 1ns/1ps

module fsm (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  a,
	input  logic                                  b,
	output logic [pr_region_pkg::OUTPUT_WIDTH-1:0] result
);

	logic [pr_region_pkg::OUTPUT_WIDTH-1:0] state;
	logic [pr_region_pkg::OUTPUT_WIDTH-1:0] state_next;

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		if (a) begin
			// A high a restarts the sequence from any state
			state_next = pr_region_pkg::FSM_SEEN_A;
		end else if (state == pr_region_pkg::FSM_SEEN_A && b) begin
			// b alone right after a completes the match
			state_next = pr_region_pkg::FSM_MATCHED;
		end else begin
			// Matched falls back to idle, as does every other case
			state_next = pr_region_pkg::FSM_IDLE;
		end
	end

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= pr_region_pkg::FSM_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Moore output, the code of the current state
	assign result = state;

endmodule

// File: source/pr_controller.sv
////////////////////
// Reconfiguration controller.
// A Wishbone classic slave with a control and a status register, and the
// sequencer that carries out a persona swap: freeze and hold the region in
// reset, switch the select as the reset releases, then thaw and drop freeze.
////////////////////

`timescale 1ns/1ps

module pr_controller (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    wb_cyc,
	input  logic                                    wb_stb,
	input  logic                                    wb_we,
	input  logic [pr_ctrl_pkg::ADDR_WIDTH-1:0]      wb_adr,
	input  logic [pr_ctrl_pkg::DATA_WIDTH-1:0]      wb_wdata,
	output logic [pr_ctrl_pkg::DATA_WIDTH-1:0]      wb_rdata,
	output logic                                    wb_ack,
	input  logic [pr_region_pkg::OUTPUT_WIDTH-1:0]  region_result,
	output logic [pr_region_pkg::PERSONA_WIDTH-1:0] persona_select,
	output logic                                    region_rst_n,
	output logic                                    freeze
);

	logic [pr_ctrl_pkg::PHASE_WIDTH-1:0]      phase;
	logic [pr_ctrl_pkg::CNT_WIDTH-1:0]        cnt;
	logic [pr_region_pkg::PERSONA_WIDTH-1:0]  pending;
	logic [pr_region_pkg::PERSONA_WIDTH-1:0]  req_persona;
	logic [pr_ctrl_pkg::DATA_WIDTH-1:0]       status;
	logic                                     busy;
	logic                                     ctrl_write;
	logic                                     swap_ok;

	////////////////////
	// Wishbone slave
	////////////////////

	// One-cycle ack the cycle after a request is seen; the ack cycle itself
	// does not start a second one for the same request
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;
		end
	end

	// Writes are acted on in their ack cycle, while the master still holds the data
	assign ctrl_write  = wb_ack & wb_we & (wb_adr == pr_ctrl_pkg::REG_CTRL);
	assign req_persona = wb_wdata[pr_ctrl_pkg::CTRL_PERSONA_LSB +: pr_region_pkg::PERSONA_WIDTH];

	// A swap needs an idle sequencer, a new persona and a legal code
	assign swap_ok = ctrl_write & ~busy & (req_persona != persona_select)
		& (req_persona < pr_region_pkg::NUM_PERSONA);

	// Status word seen by software
	always_comb begin
		status = '0;
		status[pr_ctrl_pkg::STAT_PERSONA_LSB +: pr_region_pkg::PERSONA_WIDTH] = persona_select;
		status[pr_ctrl_pkg::STAT_BUSY_BIT]   = busy;
		status[pr_ctrl_pkg::STAT_FREEZE_BIT] = freeze;
		status[pr_ctrl_pkg::STAT_RESULT_LSB +: pr_region_pkg::OUTPUT_WIDTH] = region_result;
	end

	// Read data is valid only in the ack cycle of a read
	always_comb begin
		wb_rdata = '0;
		if (wb_ack && !wb_we) begin
			case (wb_adr)
				pr_ctrl_pkg::REG_STATUS: wb_rdata = status;
				// Control reads back the persona now in the slot
				pr_ctrl_pkg::REG_CTRL: begin
					wb_rdata[pr_ctrl_pkg::CTRL_PERSONA_LSB +: pr_region_pkg::PERSONA_WIDTH] =
						persona_select;
				end
				default: wb_rdata = '0;
			endcase
		end
	end

	////////////////////
	// Swap sequencer
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase          <= pr_ctrl_pkg::PHASE_IDLE;
			cnt            <= '0;
			persona_select <= pr_region_pkg::PERSONA_AND;
		end else begin
			case (phase)
				pr_ctrl_pkg::PHASE_IDLE: begin
					if (swap_ok) begin
						// Freeze and region reset start next cycle
						phase <= pr_ctrl_pkg::PHASE_RECONFIG;
						cnt   <= pr_ctrl_pkg::CNT_WIDTH'(pr_ctrl_pkg::RECONFIG_CYCLES - 1);
					end
				end
				pr_ctrl_pkg::PHASE_RECONFIG: begin
					if (cnt == '0) begin
						// New persona is selected as its reset lifts
						phase          <= pr_ctrl_pkg::PHASE_THAW;
						cnt            <= pr_ctrl_pkg::CNT_WIDTH'(pr_ctrl_pkg::THAW_CYCLES - 1);
						persona_select <= pending;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				pr_ctrl_pkg::PHASE_THAW: begin
					if (cnt == '0) begin
						phase <= pr_ctrl_pkg::PHASE_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: phase <= pr_ctrl_pkg::PHASE_IDLE;
			endcase
		end
	end

	// Requested persona, captured with the accepted write
	always_ff @(posedge clk) begin
		if (swap_ok) begin
			pending <= req_persona;
		end
	end

	assign busy         = (phase != pr_ctrl_pkg::PHASE_IDLE);
	assign freeze       = busy;
	// Region reset covers both the top-level reset and the reconfig window
	assign region_rst_n = rst_n & (phase != pr_ctrl_pkg::PHASE_RECONFIG);

endmodule

// File: source/pr_ctrl_pkg.sv
////////////////////
// Definitions for the reconfiguration control port.
// Holds the Wishbone register map, the control and status field positions,
// and the timing of the swap sequence run by the controller.
////////////////////

package pr_ctrl_pkg;

	// Wishbone bus widths
	localparam int ADDR_WIDTH = 2;
	localparam int DATA_WIDTH = 8;

	// Register map
	localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 2'd0;
	localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 2'd1;

	// A control write carries the requested persona from this bit upward
	localparam int CTRL_PERSONA_LSB = 0;

	// Status word fields
	localparam int STAT_PERSONA_LSB = 0;
	localparam int STAT_BUSY_BIT    = 2;
	localparam int STAT_FREEZE_BIT  = 3;
	localparam int STAT_RESULT_LSB  = 4;

	// Cycles the region sits in reset, then cycles until freeze drops
	localparam int RECONFIG_CYCLES = 8;
	localparam int THAW_CYCLES     = 2;
	localparam int CNT_WIDTH       = $clog2(RECONFIG_CYCLES);

	// Sequencer phases
	localparam int PHASE_WIDTH = 2;
	localparam logic [PHASE_WIDTH-1:0] PHASE_IDLE     = 2'd0;
	localparam logic [PHASE_WIDTH-1:0] PHASE_RECONFIG = 2'd1;
	localparam logic [PHASE_WIDTH-1:0] PHASE_THAW     = 2'd2;

endpackage

// File: source/pr_region.sv
////////////////////
// The reconfigurable slot.
// Holds all three personas and routes a, b and the region reset only to
// the one chosen by persona_select. The others see zeros and stay in
// reset, so a persona swapped in always starts from its reset state.
////////////////////

`timescale 1ns/1ps

module pr_region (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [pr_region_pkg::PERSONA_WIDTH-1:0] persona_select,
	input  logic                                   a,
	input  logic                                   b,
	output logic [pr_region_pkg::OUTPUT_WIDTH-1:0]  region_result
);

	// One-hot view of the select, and the gated inputs per persona
	logic [pr_region_pkg::NUM_PERSONA-1:0] sel_hot;
	logic [pr_region_pkg::NUM_PERSONA-1:0] a_p;
	logic [pr_region_pkg::NUM_PERSONA-1:0] b_p;
	logic [pr_region_pkg::NUM_PERSONA-1:0] rst_n_p;

	// Result of each persona, indexed by persona code
	logic [pr_region_pkg::OUTPUT_WIDTH-1:0] result_p [pr_region_pkg::NUM_PERSONA];

	////////////////////
	// Input routing
	////////////////////

	for (genvar i = 0; i < pr_region_pkg::NUM_PERSONA; i++) begin : g_route
		assign sel_hot[i] = (persona_select == pr_region_pkg::PERSONA_WIDTH'(i));
		// Inactive personas see quiet inputs and a held reset
		assign a_p[i]     = a & sel_hot[i];
		assign b_p[i]     = b & sel_hot[i];
		assign rst_n_p[i] = rst_n & sel_hot[i];
	end

	////////////////////
	// Personas
	////////////////////

	and_gate u_and_gate (
		.clk    (clk),
		.rst_n  (rst_n_p[pr_region_pkg::PERSONA_AND]),
		.a      (a_p[pr_region_pkg::PERSONA_AND]),
		.b      (b_p[pr_region_pkg::PERSONA_AND]),
		.result (result_p[pr_region_pkg::PERSONA_AND])
	);

	counter u_counter (
		.clk    (clk),
		.rst_n  (rst_n_p[pr_region_pkg::PERSONA_COUNTER]),
		.a      (a_p[pr_region_pkg::PERSONA_COUNTER]),
		.b      (b_p[pr_region_pkg::PERSONA_COUNTER]),
		.result (result_p[pr_region_pkg::PERSONA_COUNTER])
	);

	fsm u_fsm (
		.clk    (clk),
		.rst_n  (rst_n_p[pr_region_pkg::PERSONA_FSM]),
		.a      (a_p[pr_region_pkg::PERSONA_FSM]),
		.b      (b_p[pr_region_pkg::PERSONA_FSM]),
		.result (result_p[pr_region_pkg::PERSONA_FSM])
	);

	////////////////////
	// Output mux
	////////////////////

	always_comb begin
		case (persona_select)
			pr_region_pkg::PERSONA_AND:     region_result = result_p[pr_region_pkg::PERSONA_AND];
			pr_region_pkg::PERSONA_COUNTER: region_result = result_p[pr_region_pkg::PERSONA_COUNTER];
			pr_region_pkg::PERSONA_FSM:     region_result = result_p[pr_region_pkg::PERSONA_FSM];
			// Unused code drives a quiet bus
			default:                        region_result = '0;
		endcase
	end

endmodule

// File: source/pr_region_pkg.sv
////////////////////
// Shared definitions for the reconfigurable region and its personas.
// Holds the persona codes used by the region mux and the controller,
// the result width every persona drives, and the FSM persona state codes.
// Referenced with scoped names from the modules that need them.
////////////////////

package pr_region_pkg;

	// Width of the result bus driven by every persona
	localparam int OUTPUT_WIDTH = 2;

	// Number of personas the slot can hold
	localparam int NUM_PERSONA = 3;

	// Width of a persona code on the select lines and in the registers
	localparam int PERSONA_WIDTH = 2;

	// Persona codes, also the index of each persona in the region
	localparam logic [PERSONA_WIDTH-1:0] PERSONA_AND     = 2'd0;
	localparam logic [PERSONA_WIDTH-1:0] PERSONA_COUNTER = 2'd1;
	localparam logic [PERSONA_WIDTH-1:0] PERSONA_FSM     = 2'd2;

	// FSM persona states; the state code is the persona's result
	localparam logic [OUTPUT_WIDTH-1:0] FSM_IDLE    = 2'd0;
	localparam logic [OUTPUT_WIDTH-1:0] FSM_SEEN_A  = 2'd1;
	localparam logic [OUTPUT_WIDTH-1:0] FSM_MATCHED = 2'd2;

endpackage

// File: source/pr_sim_wrapper.sv
////////////////////
// Top level of the partial-reconfiguration model.
// Connects the Wishbone controller, the reconfigurable region and the
// freeze block. Software swaps personas through the control register.
////////////////////

`timescale 1ns/1ps

module pr_sim_wrapper (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  a,
	input  logic                                  b,
	output logic [pr_region_pkg::OUTPUT_WIDTH-1:0] result,
	output logic                                  freeze,
	input  logic                                  wb_cyc,
	input  logic                                  wb_stb,
	input  logic                                  wb_we,
	input  logic [pr_ctrl_pkg::ADDR_WIDTH-1:0]     wb_adr,
	input  logic [pr_ctrl_pkg::DATA_WIDTH-1:0]     wb_wdata,
	output logic [pr_ctrl_pkg::DATA_WIDTH-1:0]     wb_rdata,
	output logic                                  wb_ack
);

	// Controller to region
	logic [pr_region_pkg::PERSONA_WIDTH-1:0] persona_select;
	logic                                    region_rst_n;

	// Region to freeze block and status register
	logic [pr_region_pkg::OUTPUT_WIDTH-1:0]  region_result;

	pr_controller u_pr_controller (
		.clk            (clk),
		.rst_n          (rst_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_wdata       (wb_wdata),
		.wb_rdata       (wb_rdata),
		.wb_ack         (wb_ack),
		.region_result  (region_result),
		.persona_select (persona_select),
		.region_rst_n   (region_rst_n),
		.freeze         (freeze)
	);

	// The region runs off the controller's reset, not the top-level one
	pr_region u_pr_region (
		.clk            (clk),
		.rst_n          (region_rst_n),
		.persona_select (persona_select),
		.a              (a),
		.b              (b),
		.region_result  (region_result)
	);

	freeze_logic_controller u_freeze_logic_controller (
		.clk      (clk),
		.rst_n    (rst_n),
		.data_in  (region_result),
		.freeze   (freeze),
		.data_out (result)
	);

endmodule

// File: sources.f
source/pr_region_pkg.sv
source/pr_ctrl_pkg.sv
source/and_gate.sv
source/counter.sv
source/fsm.sv
source/pr_region.sv
source/pr_controller.sv
source/freeze_logic_controller.sv
source/pr_sim_wrapper.sv
tests/tb_clock_gen.sv
tests/pr_sim_wrapper_sva.sv
tests/pr_sim_wrapper_tb.sv

// File: tests/pr_sim_wrapper_sva.sv
////////////////////
// Concurrent checks for the partial-reconfiguration top level.
// Bound into every pr_sim_wrapper instance as u_sva. Covers the Wishbone
// ack, the freeze window, result hold and the rules of each persona.
// fail_count is read by the testbench when the run ends.
////////////////////

`timescale 1ns/1ps

module pr_sim_wrapper_sva (
	input logic                                    clk,
	input logic                                    rst_n,
	input logic                                    a,
	input logic                                    b,
	input logic [pr_region_pkg::OUTPUT_WIDTH-1:0]  result,
	input logic                                    freeze,
	input logic                                    wb_cyc,
	input logic                                    wb_stb,
	input logic                                    wb_we,
	input logic [pr_ctrl_pkg::ADDR_WIDTH-1:0]      wb_adr,
	input logic [pr_ctrl_pkg::DATA_WIDTH-1:0]      wb_wdata,
	input logic                                    wb_ack,
	input logic [pr_region_pkg::PERSONA_WIDTH-1:0] persona_select
);

	localparam int FREEZE_LEN = pr_ctrl_pkg::RECONFIG_CYCLES + pr_ctrl_pkg::THAW_CYCLES;

	int   fail_count = 0;
	int   freeze_len;
	logic started = 1'b0;
	logic valid_wr;

	// Goes high after the first clock edge so $past has a history to look at
	always_ff @(posedge clk) begin
		started <= 1'b1;
	end

	// Number of consecutive cycles freeze has been high so far
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			freeze_len <= 0;
		end else if (freeze) begin
			freeze_len <= freeze_len + 1;
		end else begin
			freeze_len <= 0;
		end
	end

	// Control write that must start a swap: idle, new persona, legal code
	assign valid_wr = wb_ack && wb_we && (wb_adr == pr_ctrl_pkg::REG_CTRL) && !freeze
		&& (wb_wdata[1:0] != persona_select)
		&& (wb_wdata[1:0] < 2'(pr_region_pkg::NUM_PERSONA));

	////////////////////
	// Reset and bus
	////////////////////

	assert property (@(posedge clk) started && !$past(rst_n) |-> !wb_ack && !freeze
		&& result == '0 && persona_select == pr_region_pkg::PERSONA_AND)
		else begin
			fail_count++;
			$error("outputs not at reset values after reset");
		end

	// Ack only follows a request that was not already being acknowledged
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
		else begin
			fail_count++;
			$error("ack without a request in the cycle before");
		end

	assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else begin
			fail_count++;
			$error("ack held for more than one cycle");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		wb_cyc && wb_stb && !wb_ack |=> wb_ack)
		else begin
			fail_count++;
			$error("request not acknowledged in the next cycle");
		end

	////////////////////
	// Freeze window
	////////////////////

	assert property (@(posedge clk) disable iff (!rst_n) valid_wr |=> freeze)
		else begin
			fail_count++;
			$error("freeze did not rise after an accepted swap request");
		end

	// Busy writes and illegal codes must never start a window
	assert property (@(posedge clk) disable iff (!rst_n) $rose(freeze) |-> $past(valid_wr))
		else begin
			fail_count++;
			$error("freeze rose without an accepted swap request");
		end

	assert property (@(posedge clk) disable iff (!rst_n) $fell(freeze) |-> freeze_len == FREEZE_LEN)
		else begin
			fail_count++;
			$error("freeze window ended after %0d cycles", freeze_len);
		end

	assert property (@(posedge clk) disable iff (!rst_n) freeze |-> freeze_len < FREEZE_LEN)
		else begin
			fail_count++;
			$error("freeze window ran too long");
		end

	assert property (@(posedge clk) disable iff (!rst_n) freeze |-> $stable(result))
		else begin
			fail_count++;
			$error("result moved while frozen");
		end

	////////////////////
	// Personas
	////////////////////

	// Each rule applies only when this and the previous cycle were live
	assert property (@(posedge clk) disable iff (!rst_n)
		persona_select == pr_region_pkg::PERSONA_AND && !freeze && $past(!freeze && rst_n)
		|-> result[0] == $past(a && b) && result[1] == $past(result[0]))
		else begin
			fail_count++;
			$error("AND persona result wrong");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		persona_select == pr_region_pkg::PERSONA_COUNTER && !freeze && $past(!freeze && rst_n)
		|-> result == ($past(b) ? 2'd0 : $past(result) + 2'($past(a))))
		else begin
			fail_count++;
			$error("counter persona result wrong");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		persona_select == pr_region_pkg::PERSONA_FSM && !freeze |-> result != 2'd3)
		else begin
			fail_count++;
			$error("FSM persona reached an unused state");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		persona_select == pr_region_pkg::PERSONA_FSM && !freeze && $past(!freeze && rst_n)
		&& result == 2'd2 |-> $past(result) == 2'd1 && $past(b) && !$past(a))
		else begin
			fail_count++;
			$error("FSM persona matched without a followed by b");
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		persona_select == pr_region_pkg::PERSONA_FSM && !freeze && $past(!freeze && rst_n)
		&& result == 2'd1 |-> $past(a))
		else begin
			fail_count++;
			$error("FSM persona left idle without a");
		end

endmodule

bind pr_sim_wrapper pr_sim_wrapper_sva u_sva (
	.clk            (clk),
	.rst_n          (rst_n),
	.a              (a),
	.b              (b),
	.result         (result),
	.freeze         (freeze),
	.wb_cyc         (wb_cyc),
	.wb_stb         (wb_stb),
	.wb_we          (wb_we),
	.wb_adr         (wb_adr),
	.wb_wdata       (wb_wdata),
	.wb_ack         (wb_ack),
	.persona_select (persona_select)
);

// File: tests/pr_sim_wrapper_tb.sv
////////////////////
// Testbench for the partial-reconfiguration top level.
// Visits the AND, counter and FSM personas with random a and b, swaps
// them over Wishbone, and tries a busy write and an illegal code.
// The bound assertions check the behavior; status reads are checked here.
////////////////////

`timescale 1ns/1ps

module pr_sim_wrapper_tb;

	localparam int CLK_PERIOD_NS = 8;
	localparam int RESET_CYCLES  = 16;
	localparam int RANDOM_CYCLES = 200;
	// Window plus room for the bus transfers around one swap
	localparam int SWAP_CYCLES = pr_ctrl_pkg::RECONFIG_CYCLES + pr_ctrl_pkg::THAW_CYCLES + 20;
	localparam int RUN_CYCLES  = RESET_CYCLES + 3 * SWAP_CYCLES + 3 * RANDOM_CYCLES;

	logic       clk;
	logic       rst_n;
	logic       a;
	logic       b;
	logic [1:0] result;
	logic       freeze;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [1:0] wb_adr;
	logic [7:0] wb_wdata;
	logic [7:0] wb_rdata;
	logic       wb_ack;
	int         tb_errors = 0;

	tb_clock_gen u_clock_gen (
		.clk (clk)
	);

	pr_sim_wrapper uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.a        (a),
		.b        (b),
		.result   (result),
		.freeze   (freeze),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack)
	);

	////////////////////
	// Stimulus tasks
	////////////////////

	// Random inputs, one new pair per cycle
	task automatic drive_random(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
			a = 1'($urandom);
			b = 1'($urandom);
		end
	endtask

	// Wishbone classic write, held through the ack cycle
	task automatic wb_write(input logic [1:0] adr, input logic [7:0] data);
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_wdata = data;
		@(posedge clk);
		#1;
		while (!wb_ack) begin
			@(posedge clk);
			#1;
		end
		// The slave takes the write at the edge that closes the ack cycle
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// Status read, compared with persona, idle flags and the live result
	task automatic wb_read(input string test_name, input logic [1:0] exp_persona);
		logic [7:0] expected;
		logic [7:0] got;
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = pr_ctrl_pkg::REG_STATUS;
		@(posedge clk);
		#1;
		while (!wb_ack) begin
			@(posedge clk);
			#1;
		end
		got = wb_rdata;
		expected = {2'b00, result, 1'b0, 1'b0, exp_persona};
		// Transfer ends at the edge that closes the ack cycle
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		if (got !== expected) begin
			tb_errors++;
			$display("Error %s: expected %h, actual %h", test_name, expected, got);
		end
	endtask

	task automatic wait_freeze(input logic level);
		while (freeze !== level) begin
			@(posedge clk);
			#1;
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		void'($urandom(32'h439731c2));
		rst_n = 1'b0;
		a = 1'b0;
		b = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wb_read("after_reset", pr_region_pkg::PERSONA_AND);
		drive_random(RANDOM_CYCLES);

		// Swap to the counter; the FSM request in the window is dropped
		wb_write(pr_ctrl_pkg::REG_CTRL, {6'd0, pr_region_pkg::PERSONA_COUNTER});
		wait_freeze(1'b1);
		wb_write(pr_ctrl_pkg::REG_CTRL, {6'd0, pr_region_pkg::PERSONA_FSM});
		wait_freeze(1'b0);
		wb_read("swap_to_counter", pr_region_pkg::PERSONA_COUNTER);
		drive_random(RANDOM_CYCLES);

		// Code 3 names no persona and must leave the slot alone
		wb_write(pr_ctrl_pkg::REG_CTRL, 8'h03);
		wb_read("invalid_code", pr_region_pkg::PERSONA_COUNTER);

		wb_write(pr_ctrl_pkg::REG_CTRL, {6'd0, pr_region_pkg::PERSONA_FSM});
		wait_freeze(1'b1);
		wait_freeze(1'b0);
		wb_read("swap_to_fsm", pr_region_pkg::PERSONA_FSM);
		drive_random(RANDOM_CYCLES);

		wb_write(pr_ctrl_pkg::REG_CTRL, {6'd0, pr_region_pkg::PERSONA_AND});
		wait_freeze(1'b1);
		wait_freeze(1'b0);
		wb_read("swap_to_and", pr_region_pkg::PERSONA_AND);
		drive_random(8);

		$display("Checks done: %0d status errors, %0d assertion failures",
			tb_errors, uut.u_sva.fail_count);
		if (tb_errors == 0 && uut.u_sva.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Twice the expected run length before giving up
	initial begin
		#(RUN_CYCLES * CLK_PERIOD_NS * 2);
		$display("Run timed out before the stimulus finished");
		$display("Test failed");
		$finish;
	end

endmodule

// File: tests/tb_clock_gen.sv
////////////////////
// Free-running clock for the testbench.
// Starts low and toggles every half period.
////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	// 8 ns period with the default half period
	always #(HALF_PERIOD_NS) clk = ~clk;

endmodule
